//--- logic/music_box_pkg.sv
package music_box_pkg;

    localparam int PITCH_W    = 3;
    localparam int BEATS_W    = 3;
    localparam int SPEED_W    = 2;
    localparam int SONG_SEL_W = 2;
    localparam int FIFO_DEPTH = 8;
    localparam int SONG_LEN   = 8;
    localparam int SONG_COUNT = 4;
    localparam int DUR_W      = 7;  // Up to 7 beats of 12 cycles
    localparam int HALF_W     = 4;

    // Note view of a song word
    typedef struct packed {
        logic               kind;  // 0 here
        logic [PITCH_W-1:0] pitch;  // 0 is a rest
        logic [BEATS_W-1:0] beats;
        logic               pad;
    } note_t;

    // Control view, kind is 1
    typedef struct packed {
        logic       kind;
        logic       loop;  // Clear for stop
        logic [5:0] pad;
    } ctrl_t;

    typedef union packed {
        note_t note;
        ctrl_t ctrl;
    } song_word_t;

    typedef struct packed {
        logic [PITCH_W-1:0] pitch;
        logic [BEATS_W-1:0] beats;
        logic [SPEED_W-1:0] speed;
    } note_entry_t;

    typedef struct packed {
        logic                  start;
        logic [SONG_SEL_W-1:0] song;
        logic [SPEED_W-1:0]    speed;
    } buttons_t;

    typedef struct packed {
        logic               strobe;
        logic [PITCH_W-1:0] pitch;
        logic [BEATS_W-1:0] beats;
    } note_event_t;

    // Pitch n plays with a half period of n+1 cycles
    localparam int HALF_PERIOD [2**PITCH_W] = '{1, 2, 3, 4, 5, 6, 7, 8};

    // Cycles per beat, slowest speed code first
    localparam int BEAT_CYCLES [2**SPEED_W] = '{12, 8, 6, 4};

    localparam logic [7:0] STOP_WORD = 8'h80;
    localparam logic [7:0] LOOP_WORD = 8'hC0;

    // Note words laid out as kind_pitch_beats_pad
    localparam song_word_t SONG_ROM [SONG_LEN*SONG_COUNT] = '{
        8'b0_001_010_0, 8'b0_010_001_0, 8'b0_011_001_0, 8'b0_100_010_0,  // Song 0
        8'b0_101_001_0, 8'b0_110_001_0, 8'b0_111_011_0, STOP_WORD,
        8'b0_101_001_0, 8'b0_011_001_0, 8'b0_001_010_0, 8'b0_011_001_0,  // Song 1
        8'b0_101_010_0, LOOP_WORD,      STOP_WORD,      STOP_WORD,
        8'b0_010_010_0, 8'b0_000_010_0, 8'b0_100_001_0, 8'b0_000_001_0,  // Song 2, rests
        8'b0_110_010_0, STOP_WORD,      STOP_WORD,      STOP_WORD,
        8'b0_011_010_0, STOP_WORD,      STOP_WORD,      STOP_WORD,       // Song 3
        STOP_WORD,      STOP_WORD,      STOP_WORD,      STOP_WORD
    };

endpackage

//--- logic/debounce.sv
module debounce #(
    parameter int DEBOUNCE_DELAY = 100000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  music_box_pkg::buttons_t raw,
    output music_box_pkg::buttons_t clean
);
    import music_box_pkg::*;

    localparam int NUM_BITS = $bits(buttons_t);

    logic [NUM_BITS-1:0] raw_bits;
    logic [NUM_BITS-1:0] clean_bits;

    assign raw_bits = raw;
    assign clean    = clean_bits;

    for (genvar i = 0; i < NUM_BITS; i++) begin : g_bit
        logic [$clog2(DEBOUNCE_DELAY+1)-1:0] cnt;

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt           <= '0;
                clean_bits[i] <= 1'b0;
            end else if (raw_bits[i] == clean_bits[i]) begin
                cnt <= '0;  // Input agrees, start over
            end else if (cnt == DEBOUNCE_DELAY) begin
                clean_bits[i] <= raw_bits[i];
                cnt           <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        // The new level was already on the input a full delay earlier
        assert property (@(posedge clk) disable iff (rst)
            !$stable(clean_bits[i])
                |-> ($past(raw_bits[i], DEBOUNCE_DELAY + 1) == clean_bits[i]));
    end

endmodule

//--- logic/song_sequencer.sv
module song_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  music_box_pkg::buttons_t    clean,
    input  logic                       full,
    output logic                       push,
    output music_box_pkg::note_entry_t push_data
);
    import music_box_pkg::*;

    logic                        busy;
    logic                        start_q;
    logic                        start_rise;
    logic [SONG_SEL_W-1:0]       song_q;
    logic [SPEED_W-1:0]          speed_q;
    logic [$clog2(SONG_LEN)-1:0] idx;
    song_word_t                  word;

    assign start_rise = clean.start & ~start_q;
    assign word       = SONG_ROM[{song_q, idx}];  // Song base plus offset

    // A note word goes out unless the FIFO is full or start cancels
    assign push = busy && !word.note.kind && !full && !start_rise;

    assign push_data.pitch = word.note.pitch;
    assign push_data.beats = word.note.beats;
    assign push_data.speed = speed_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            start_q <= 1'b0;
            idx     <= '0;
        end else begin
            start_q <= clean.start;
            if (start_rise) begin
                busy <= ~busy;  // Start when idle, stop when busy
                idx  <= '0;
            end else if (busy) begin
                if (word.ctrl.kind) begin
                    if (word.ctrl.loop) begin
                        idx <= '0;
                    end else begin
                        busy <= 1'b0;
                    end
                end else if (!full) begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Selection only sampled when a song starts
    always_ff @(posedge clk) begin
        if (start_rise && !busy) begin
            song_q  <= clean.song;
            speed_q <= clean.speed;
        end
    end

    // Every pushed note moves the read on by one word
    assert property (@(posedge clk) disable iff (rst)
        push |=> (idx == $past(idx) + 1'b1));

endmodule

//--- logic/note_fifo.sv
module note_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  music_box_pkg::note_entry_t push_data,
    output logic                       full,
    input  logic                       pop,
    output music_box_pkg::note_entry_t pop_data,
    output logic                       empty
);
    import music_box_pkg::*;

    note_entry_t                      mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]  count;
    logic                             do_push;
    logic                             do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == FIFO_DEPTH);
    assign empty    = (count == 0);
    assign pop_data = mem[rd_ptr];  // Head shown combinationally

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Power of two depth wraps
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    assert property (@(posedge clk) disable iff (rst) full |-> !push);
    assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

//--- logic/tone_generator.sv
module tone_generator (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       empty,
    input  music_box_pkg::note_entry_t pop_data,
    output logic                       pop,
    output logic                       tone_out,
    output music_box_pkg::note_event_t note_event,
    output logic                       playing
);
    import music_box_pkg::*;

    logic                active;
    logic                note_end;
    logic                strobe;
    logic [DUR_W-1:0]    dur_cnt;  // Cycles left in the note
    logic [HALF_W-1:0]   half_cnt;
    logic [PITCH_W-1:0]  pitch_q;
    logic [BEATS_W-1:0]  beats_q;

    assign note_end = active && (dur_cnt == DUR_W'(1));

    // Take the next note on its predecessor's last cycle, no gap
    assign pop     = !empty && (!active || note_end);
    assign playing = active;

    assign note_event.strobe = strobe;
    assign note_event.pitch  = pitch_q;
    assign note_event.beats  = beats_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            strobe   <= 1'b0;
            tone_out <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else begin
            strobe <= pop;
            if (pop) begin
                active   <= 1'b1;
                tone_out <= 1'b0;  // Every note starts low
                dur_cnt  <= DUR_W'(pop_data.beats * BEAT_CYCLES[pop_data.speed]);
                half_cnt <= HALF_W'(HALF_PERIOD[pop_data.pitch]);
            end else if (active) begin
                dur_cnt <= dur_cnt - 1'b1;
                if (note_end) begin
                    active   <= 1'b0;
                    tone_out <= 1'b0;
                end else if (half_cnt == HALF_W'(1)) begin
                    half_cnt <= HALF_W'(HALF_PERIOD[pitch_q]);
                    if (pitch_q != '0) tone_out <= ~tone_out;  // Rest stays low
                end else begin
                    half_cnt <= half_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pitch_q <= pop_data.pitch;
            beats_q <= pop_data.beats;
        end
    end

    // A note announced while silent would be lost
    assert property (@(posedge clk) disable iff (rst)
        note_event.strobe |-> (playing && !tone_out));

endmodule

//--- logic/music_box_top.sv
module music_box_top #(
    parameter int DEBOUNCE_DELAY = 100000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  music_box_pkg::buttons_t    buttons,
    output logic                       tone_out,
    output music_box_pkg::note_event_t note_event,
    output logic                       playing
);
    import music_box_pkg::*;

    buttons_t    clean;
    logic        push;
    logic        full;
    note_entry_t push_data;
    logic        pop;
    logic        empty;
    note_entry_t pop_data;

    debounce #(
        .DEBOUNCE_DELAY(DEBOUNCE_DELAY)
    ) u_debounce (
        .clk  (clk),
        .rst  (rst),
        .raw  (buttons),
        .clean(clean)
    );

    song_sequencer u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .clean    (clean),
        .full     (full),
        .push     (push),
        .push_data(push_data)
    );

    note_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_data(push_data),
        .full     (full),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty)
    );

    tone_generator u_tone (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .pop_data  (pop_data),
        .pop       (pop),
        .tone_out  (tone_out),
        .note_event(note_event),
        .playing   (playing)
    );

endmodule

//--- sim/music_box_tb.sv
module music_box_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import music_box_pkg::*;

    localparam int DEBOUNCE_DELAY = 8;
    localparam int NUM_ROWS       = 4;
    localparam int GLITCHES       = 4;

    typedef struct {
        string name;
        int    song;
        int    speed;
        bit    glitch;
        int    notes;
    } row_t;

    // The loop song is checked past its loop word
    row_t rows [NUM_ROWS] = '{
        '{"song0_speed0",        0, 0, 1'b1, 7},
        '{"song1_loop_speed3",   1, 3, 1'b0, 7},
        '{"song2_rests_speed1",  2, 1, 1'b1, 5},
        '{"song3_single_speed2", 3, 2, 1'b0, 1}
    };

    logic        clk;
    logic        rst;
    buttons_t    buttons;
    logic        tone_out;
    note_event_t note_event;
    logic        playing;

    int cycle_count = 0;
    int cycle_limit = 0;

    music_box_top #(
        .DEBOUNCE_DELAY(DEBOUNCE_DELAY)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .tone_out  (tone_out),
        .note_event(note_event),
        .playing   (playing)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic string event_text(input note_event_t ev);
        return $sformatf("strobe %0b pitch %0d beats %0d", ev.strobe, ev.pitch, ev.beats);
    endfunction

    task automatic check_event(input string name, input note_event_t expected,
                               input note_event_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %s, actual %s",
                     name, event_text(expected), event_text(actual));
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Inputs change and outputs are sampled 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Walks the song table, following loop words, to the n-th note
    function automatic note_event_t expected_note(input int song, input int n);
        song_word_t  w;
        int          idx;
        int          seen;
        note_event_t ev;
        idx  = 0;
        seen = 0;
        ev   = '0;  // No strobe means the song stopped first
        for (int guard = 0; guard < 64; guard++) begin
            w = SONG_ROM[song * SONG_LEN + idx];
            if (w.ctrl.kind) begin
                if (!w.ctrl.loop) break;
                idx = 0;
            end else if (seen == n) begin
                ev.strobe = 1'b1;
                ev.pitch  = w.note.pitch;
                ev.beats  = w.note.beats;
                return ev;
            end else begin
                seen++;
                idx++;
            end
        end
        return ev;
    endfunction

    task automatic wait_idle(input string name, input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_bit({name, " playing stays low"}, 1'b0, playing);
            check_bit({name, " no strobe while idle"}, 1'b0, note_event.strobe);
        end
    endtask

    task automatic select_song(input row_t r);
        buttons.song  = SONG_SEL_W'(r.song);
        buttons.speed = SPEED_W'(r.speed);
        wait_idle(r.name, DEBOUNCE_DELAY + 3);
    endtask

    // Start pulses too short to pass the debouncer
    task automatic send_glitches(input string name);
        int width;
        for (int g = 0; g < GLITCHES; g++) begin
            width = int'($urandom % (DEBOUNCE_DELAY - 1)) + 1;
            buttons.start = 1'b1;
            wait_idle({name, " glitch"}, width);
            buttons.start = 1'b0;
            wait_idle({name, " after glitch"}, DEBOUNCE_DELAY + 3);
        end
    endtask

    task automatic press_start();
        buttons.start = 1'b1;
        next_cycle();
        while (!note_event.strobe) begin
            next_cycle();
        end
        buttons.start = 1'b0;
    endtask

    task automatic follow_notes(input row_t r);
        note_event_t expected;
        string       tag;
        int          half;
        int          run_len;
        int          k;
        logic        prev_tone;
        for (int i = 0; i < r.notes; i++) begin
            expected = expected_note(r.song, i);
            tag = $sformatf("%s note %0d", r.name, i);
            check_event(tag, expected, note_event);
            check_bit({tag, " tone low at start"}, 1'b0, tone_out);
            half      = HALF_PERIOD[expected.pitch];
            prev_tone = tone_out;
            run_len   = 1;
            k         = 1;
            next_cycle();
            while (playing && !note_event.strobe) begin
                if (expected.pitch == '0) begin
                    check_bit({tag, " rest stays low"}, 1'b0, tone_out);
                end else if (tone_out !== prev_tone) begin
                    check_cycles({tag, " half period"}, half, run_len);
                    prev_tone = tone_out;
                    run_len   = 1;
                end else begin
                    run_len++;
                    if (run_len > half) check_cycles({tag, " missing toggle"}, half, run_len);
                end
                k++;
                next_cycle();
            end
            check_cycles({tag, " spacing"}, expected.beats * BEAT_CYCLES[r.speed], k);
        end
    endtask

    // Checks a queued note as it starts, then moves on one cycle
    task automatic drain_step(input row_t r, inout int n);
        if (note_event.strobe) begin
            check_event($sformatf("%s drain note %0d", r.name, n),
                        expected_note(r.song, n), note_event);
            n++;
        end
        next_cycle();
    endtask

    // Second press cancels the loop, queued notes drain in order
    task automatic stop_loop(input row_t r);
        int n;
        n = r.notes;
        buttons.start = 1'b1;
        repeat (DEBOUNCE_DELAY + 3) begin
            drain_step(r, n);
        end
        buttons.start = 1'b0;
        check_bit({r.name, " queued notes still play"}, 1'b1, playing);
        while (playing) begin
            drain_step(r, n);
        end
    endtask

    task automatic run_row(input row_t r);
        note_event_t after_last;
        select_song(r);
        if (r.glitch) send_glitches(r.name);
        press_start();
        follow_notes(r);
        after_last = expected_note(r.song, r.notes);
        if (after_last.strobe) begin
            stop_loop(r);
        end else begin
            check_bit({r.name, " playing falls after last note"}, 1'b0, playing);
        end
        wait_idle({r.name, " end"}, DEBOUNCE_DELAY + 4);
    endtask

    initial begin
        void'($urandom(57013));
        rst     = 1'b1;
        buttons = '0;
        foreach (rows[i]) begin
            cycle_limit += rows[i].notes * 7 * 12 + 200;  // Longest note, slowest speed
        end
        repeat (2) begin
            next_cycle();
        end
        rst = 1'b0;
        check_bit("after reset playing", 1'b0, playing);
        check_bit("after reset tone_out", 1'b0, tone_out);
        check_bit("after reset strobe", 1'b0, note_event.strobe);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sim.f
logic/music_box_pkg.sv
logic/debounce.sv
logic/song_sequencer.sv
logic/note_fifo.sv
logic/tone_generator.sv
logic/music_box_top.sv
sim/music_box_tb.sv

//--- Makefile
SRCS := sim.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)

all: run

obj_dir/Vmusic_box_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module music_box_tb -f sim.f -o Vmusic_box_tb

run: obj_dir/Vmusic_box_tb
	-./obj_dir/Vmusic_box_tb > sim.log 2>&1
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
